// File: Makefile
VERILATOR ?= verilator
TOP       := dispatch_tb
FILELIST  := vlog.f
VFLAGS    := --binary --timing --assert -Wno-fatal --top-module $(TOP)
OBJ_DIR   := obj_dir
SIM       := $(OBJ_DIR)/V$(TOP)
LOG       := sim.log
SRCS      := $(shell grep -v '^+' $(FILELIST)) $(wildcard rtl/*.svh verification/*.svh)

.PHONY: all run clean

all: run

$(SIM): $(SRCS) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --Mdir $(OBJ_DIR) -f $(FILELIST)

run: $(SIM)
	./$(SIM) > $(LOG) 2>&1 || true
	@cat $(LOG)
	@if grep -q "TEST RESULT: FAIL" $(LOG) || ! grep -q "TEST RESULT: PASS" $(LOG); then exit 1; fi

clean:
	rm -rf $(OBJ_DIR) $(LOG)

// File: rtl/busy_table.sv
`timescale 1ns/1ps
`include "core_defines.svh"

module busy_table
    import uop_pkg::*;
(
    input  logic     clk,
    input  logic     rst,
    input  prf_num_t set_num_0,
    input  prf_num_t set_num_1,
    input  logic     set_en_0,
    input  logic     set_en_1,
    input  prf_num_t wb_num,
    input  logic     wb_en,
    input  prf_num_t rd_num_0_0,
    input  prf_num_t rd_num_0_1,
    input  prf_num_t rd_num_1_0,
    input  prf_num_t rd_num_1_1,
    output logic     busy_0_0,
    output logic     busy_0_1,
    output logic     busy_1_0,
    output logic     busy_1_1
);

    localparam int NUM_PRF = 1 << `PRF_NUM_W;

    logic [NUM_PRF-1:0] busy_q;

    always_ff @(posedge clk) begin
        if (rst) begin
            busy_q <= '0;
        end else begin
            if (wb_en) begin
                busy_q[wb_num] <= 1'b0;
            end
            // later assignments win, so a new owner beats the writeback
            if (set_en_0) begin
                busy_q[set_num_0] <= 1'b1;
            end
            if (set_en_1) begin
                busy_q[set_num_1] <= 1'b1;
            end
        end
    end

    // no writeback bypass, reads see last cycle's state
    assign busy_0_0 = busy_q[rd_num_0_0];
    assign busy_0_1 = busy_q[rd_num_0_1];
    assign busy_1_0 = busy_q[rd_num_1_0];
    assign busy_1_1 = busy_q[rd_num_1_1];

endmodule

// File: rtl/core_defines.svh
`ifndef CORE_DEFINES_SVH
`define CORE_DEFINES_SVH

// physical register number width
`define PRF_NUM_W 6

// bundle-level reorder buffer id, the slot bit is appended below it
`define ROB_ID_W 7

// reorder buffer capacity in micro-ops
`define ROB_DEPTH 16

// entries per issue queue
`define IQ_DEPTH 8

// logical register number width
`define ARCH_W 5

`endif

// File: rtl/dispatch.sv
`timescale 1ns/1ps

module dispatch
    import uop_pkg::*;
    import sched_pkg::*;
(
    input  logic         clk,
    input  logic         rst,
    input  logic         stall,
    input  uop_t         uop_0,
    input  uop_t         uop_1,
    input  rob_id_t      rob_next_id,
    input  logic         rob_empty,
    input  logic         rob_ready,
    input  logic         alu_has_room,
    input  logic         lsu_has_room,
    input  logic         src_busy_0_0,
    input  logic         src_busy_0_1,
    input  logic         src_busy_1_0,
    input  logic         src_busy_1_1,
    output prf_num_t     src_num_0_0,
    output prf_num_t     src_num_0_1,
    output prf_num_t     src_num_1_0,
    output prf_num_t     src_num_1_1,
    output prf_num_t     set_num_0,
    output prf_num_t     set_num_1,
    output logic         set_en_0,
    output logic         set_en_1,
    output logic         rob_wen,
    output logic [1:0]   rob_count,
    output logic         alu_wen_0,
    output logic         alu_wen_1,
    output queue_entry_t alu_entry_0,
    output queue_entry_t alu_entry_1,
    output logic         lsu_wen_0,
    output logic         lsu_wen_1,
    output queue_entry_t lsu_entry_0,
    output queue_entry_t lsu_entry_1,
    output logic         mdu_valid,
    output mdu_entry_t   mdu_entry,
    output logic         pause_req
);

    dispatch_state_e state, state_next;
    logic            has_priv;
    logic            both_valid;
    logic            go;
    uop_t            sel_0, sel_1;
    uop_t            tag_0, tag_1;
    queue_entry_t    ent_0, ent_1;
    logic            rdy_0_0, rdy_0_1, rdy_1_0, rdy_1_1;
    logic            alu_0, alu_1, lsu_0, lsu_1;

    assign has_priv   = (uop_0.valid && uop_0.is_priv) || (uop_1.valid && uop_1.is_priv);
    assign both_valid = uop_0.valid && uop_1.valid;
    // a write may proceed this cycle
    assign go         = !stall && alu_has_room && lsu_has_room;

    always_ff @(posedge clk) begin
        if (rst) begin
            state <= IDLE;
        end else begin
            state <= state_next;
        end
    end

    // privileged ops enter one at a time into an empty ROB
    always_comb begin
        state_next = state;
        case (state)
            IDLE:       if (has_priv) state_next = WAIT_SLOT0;
            WAIT_SLOT0: if (rob_empty && go) state_next = WR_SLOT0;
            WR_SLOT0:   if (go) state_next = both_valid ? WAIT_SLOT1 : DONE;
            WAIT_SLOT1: if (rob_empty && go) state_next = WR_SLOT1;
            WR_SLOT1:   if (go) state_next = DONE;
            DONE:       state_next = IDLE;
            default:    state_next = IDLE;
        endcase
    end

    // rename holds its bundle while this is high
    always_comb begin
        case (state)
            IDLE:    pause_req = !rob_ready || !alu_has_room || !lsu_has_room || has_priv;
            DONE:    pause_req = 1'b0;
            default: pause_req = 1'b1;
        endcase
    end

    // bundle that goes out this cycle, cleared when nothing is written
    always_comb begin
        sel_0 = '0;
        sel_1 = '0;
        case (state)
            IDLE: begin
                if (!pause_req && !stall) begin
                    sel_0 = uop_0;
                    sel_1 = uop_1;
                end
            end
            WR_SLOT0: if (go) sel_0 = uop_0.valid ? uop_0 : uop_1;
            // second privileged op enters alone, so it takes slot bit 0
            WR_SLOT1: if (go) sel_0 = uop_1;
            default: ;
        endcase
    end

    always_comb begin
        tag_0      = sel_0;
        tag_0.id   = {rob_next_id, 1'b0};
        tag_0.busy = sel_0.valid && sel_0.code != OP_NOP && sel_0.code != OP_MDBUBBLE;
        tag_1      = sel_1;
        tag_1.id   = {rob_next_id, 1'b1};
        tag_1.busy = sel_1.valid && sel_1.code != OP_NOP && sel_1.code != OP_MDBUBBLE;
    end

    assign rob_wen   = sel_0.valid || sel_1.valid;
    assign rob_count = {1'b0, sel_0.valid} + {1'b0, sel_1.valid};

    // scoreboard lookups and busy marking
    assign src_num_0_0 = sel_0.src0_preg;
    assign src_num_0_1 = sel_0.src1_preg;
    assign src_num_1_0 = sel_1.src0_preg;
    assign src_num_1_1 = sel_1.src1_preg;
    assign set_num_0   = sel_0.dst_preg;
    assign set_num_1   = sel_1.dst_preg;
    assign set_en_0    = sel_0.valid && sel_0.dst_en;
    assign set_en_1    = sel_1.valid && sel_1.dst_en;

    // r0 and unused sources are always ready
    assign rdy_0_0 = !sel_0.src0_en || sel_0.src0_lreg == '0 || !src_busy_0_0;
    assign rdy_0_1 = !sel_0.src1_en || sel_0.src1_lreg == '0 || !src_busy_0_1;
    // slot 1 may also depend on slot 0 of the same bundle
    assign rdy_1_0 = !sel_1.src0_en || sel_1.src0_lreg == '0 ||
                     (!src_busy_1_0 && !(set_en_0 && sel_1.src0_preg == set_num_0));
    assign rdy_1_1 = !sel_1.src1_en || sel_1.src1_lreg == '0 ||
                     (!src_busy_1_1 && !(set_en_0 && sel_1.src1_preg == set_num_0));

    always_comb begin
        ent_0 = '{uop: tag_0, src0_ready: rdy_0_0, src1_ready: rdy_0_1,
                  is_store: code_is_store(tag_0.code)};
        ent_1 = '{uop: tag_1, src0_ready: rdy_1_0, src1_ready: rdy_1_1,
                  is_store: code_is_store(tag_1.code)};
    end

    assign alu_0 = sel_0.valid && sel_0.rs_type == RS_ALU;
    assign alu_1 = sel_1.valid && sel_1.rs_type == RS_ALU;
    assign lsu_0 = sel_0.valid && sel_0.rs_type == RS_LSU;
    assign lsu_1 = sel_1.valid && sel_1.rs_type == RS_LSU;

    // a lone match is packed into port 0
    assign alu_wen_0   = alu_0 || alu_1;
    assign alu_wen_1   = alu_0 && alu_1;
    assign alu_entry_0 = alu_0 ? ent_0 : ent_1;
    assign alu_entry_1 = ent_1;

    assign lsu_wen_0   = lsu_0 || lsu_1;
    assign lsu_wen_1   = lsu_0 && lsu_1;
    assign lsu_entry_0 = lsu_0 ? ent_0 : ent_1;
    assign lsu_entry_1 = ent_1;

    assign mdu_valid = sel_0.valid && sel_0.rs_type == RS_MDU;
    assign mdu_entry = '{uop_hi: tag_0, uop_lo: tag_1, src0_ready: rdy_0_0,
                         src1_ready: rdy_0_1, is_mul: code_is_mul(tag_0.code)};

    a_alu_pack: assert property (@(posedge clk) disable iff (rst)
        alu_wen_1 |-> alu_wen_0);

    a_lsu_pack: assert property (@(posedge clk) disable iff (rst)
        lsu_wen_1 |-> lsu_wen_0);

    a_wr_slot1_exit: assert property (@(posedge clk) disable iff (rst)
        state == WR_SLOT1 |=> state inside {WR_SLOT1, DONE});

endmodule

// File: rtl/dispatch_top.sv
`timescale 1ns/1ps
`include "core_defines.svh"

module dispatch_top
    import uop_pkg::*;
    import sched_pkg::*;
(
    input  logic         clk,
    input  logic         rst,
    input  logic         stall,
    input  uop_t         uop_0,
    input  uop_t         uop_1,
    input  logic [1:0]   retire_count,
    input  prf_num_t     wb_num,
    input  logic         wb_en,
    input  logic         alu_pop,
    input  logic         lsu_pop,
    output logic         pause_req,
    output queue_entry_t alu_head,
    output logic         alu_head_valid,
    output queue_entry_t lsu_head,
    output logic         lsu_head_valid,
    output logic         mdu_valid,
    output mdu_entry_t   mdu_entry,
    output logic         rob_empty
);

    rob_id_t      rob_next_id;
    logic         rob_ready, rob_wen;
    logic [1:0]   rob_count;
    logic         alu_has_room, lsu_has_room;
    prf_num_t     src_num_0_0, src_num_0_1, src_num_1_0, src_num_1_1;
    logic         src_busy_0_0, src_busy_0_1, src_busy_1_0, src_busy_1_1;
    prf_num_t     set_num_0, set_num_1;
    logic         set_en_0, set_en_1;
    logic         alu_wen_0, alu_wen_1, lsu_wen_0, lsu_wen_1;
    queue_entry_t alu_entry_0, alu_entry_1, lsu_entry_0, lsu_entry_1;

    dispatch u_dispatch (
        .clk          (clk),
        .rst          (rst),
        .stall        (stall),
        .uop_0        (uop_0),
        .uop_1        (uop_1),
        .rob_next_id  (rob_next_id),
        .rob_empty    (rob_empty),
        .rob_ready    (rob_ready),
        .alu_has_room (alu_has_room),
        .lsu_has_room (lsu_has_room),
        .src_busy_0_0 (src_busy_0_0),
        .src_busy_0_1 (src_busy_0_1),
        .src_busy_1_0 (src_busy_1_0),
        .src_busy_1_1 (src_busy_1_1),
        .src_num_0_0  (src_num_0_0),
        .src_num_0_1  (src_num_0_1),
        .src_num_1_0  (src_num_1_0),
        .src_num_1_1  (src_num_1_1),
        .set_num_0    (set_num_0),
        .set_num_1    (set_num_1),
        .set_en_0     (set_en_0),
        .set_en_1     (set_en_1),
        .rob_wen      (rob_wen),
        .rob_count    (rob_count),
        .alu_wen_0    (alu_wen_0),
        .alu_wen_1    (alu_wen_1),
        .alu_entry_0  (alu_entry_0),
        .alu_entry_1  (alu_entry_1),
        .lsu_wen_0    (lsu_wen_0),
        .lsu_wen_1    (lsu_wen_1),
        .lsu_entry_0  (lsu_entry_0),
        .lsu_entry_1  (lsu_entry_1),
        .mdu_valid    (mdu_valid),
        .mdu_entry    (mdu_entry),
        .pause_req    (pause_req)
    );

    rob_alloc u_rob_alloc (
        .clk          (clk),
        .rst          (rst),
        .wen          (rob_wen),
        .count        (rob_count),
        .retire_count (retire_count),
        .next_id      (rob_next_id),
        .empty        (rob_empty),
        .ready        (rob_ready)
    );

    busy_table u_busy_table (
        .clk        (clk),
        .rst        (rst),
        .set_num_0  (set_num_0),
        .set_num_1  (set_num_1),
        .set_en_0   (set_en_0),
        .set_en_1   (set_en_1),
        .wb_num     (wb_num),
        .wb_en      (wb_en),
        .rd_num_0_0 (src_num_0_0),
        .rd_num_0_1 (src_num_0_1),
        .rd_num_1_0 (src_num_1_0),
        .rd_num_1_1 (src_num_1_1),
        .busy_0_0   (src_busy_0_0),
        .busy_0_1   (src_busy_0_1),
        .busy_1_0   (src_busy_1_0),
        .busy_1_1   (src_busy_1_1)
    );

    issue_queue #(.DEPTH(`IQ_DEPTH)) u_alu_iq (
        .clk        (clk),
        .rst        (rst),
        .wen_0      (alu_wen_0),
        .wen_1      (alu_wen_1),
        .entry_0    (alu_entry_0),
        .entry_1    (alu_entry_1),
        .pop        (alu_pop),
        .head       (alu_head),
        .head_valid (alu_head_valid),
        .has_room   (alu_has_room)
    );

    issue_queue #(.DEPTH(`IQ_DEPTH)) u_lsu_iq (
        .clk        (clk),
        .rst        (rst),
        .wen_0      (lsu_wen_0),
        .wen_1      (lsu_wen_1),
        .entry_0    (lsu_entry_0),
        .entry_1    (lsu_entry_1),
        .pop        (lsu_pop),
        .head       (lsu_head),
        .head_valid (lsu_head_valid),
        .has_room   (lsu_has_room)
    );

endmodule

// File: rtl/issue_queue.sv
`timescale 1ns/1ps
`include "core_defines.svh"

module issue_queue
    import sched_pkg::*;
#(
    // power of two so the pointers wrap on their own
    parameter int DEPTH = `IQ_DEPTH
) (
    input  logic         clk,
    input  logic         rst,
    input  logic         wen_0,
    input  logic         wen_1,
    input  queue_entry_t entry_0,
    input  queue_entry_t entry_1,
    input  logic         pop,
    output queue_entry_t head,
    output logic         head_valid,
    output logic         has_room
);

    localparam int PTR_W = $clog2(DEPTH);
    localparam int CNT_W = PTR_W + 1;

    queue_entry_t     mem [DEPTH];
    logic [PTR_W-1:0] wr_ptr, rd_ptr;
    logic [CNT_W-1:0] count;
    logic [1:0]       n_wr;
    logic             do_pop;

    assign n_wr   = {1'b0, wen_0} + {1'b0, wen_1};
    assign do_pop = pop && head_valid;

    // port 1 lands right behind port 0
    always_ff @(posedge clk) begin
        if (wen_0) begin
            mem[wr_ptr] <= entry_0;
        end
        if (wen_1) begin
            mem[wr_ptr + PTR_W'(1)] <= entry_1;
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else begin
            wr_ptr <= wr_ptr + PTR_W'(n_wr);
            if (do_pop) begin
                rd_ptr <= rd_ptr + 1'b1;
            end
            count <= count + CNT_W'(n_wr) - CNT_W'(do_pop);
        end
    end

    assign head       = mem[rd_ptr];
    assign head_valid = count != '0;
    assign has_room   = count <= CNT_W'(DEPTH - 2);

    // the dispatcher must hold off when room is gone
    a_no_overflow: assert property (@(posedge clk) disable iff (rst)
        !has_room |-> !wen_0 && !wen_1);

endmodule

// File: rtl/rob_alloc.sv
`timescale 1ns/1ps
`include "core_defines.svh"

module rob_alloc
    import sched_pkg::*;
(
    input  logic       clk,
    input  logic       rst,
    input  logic       wen,
    input  logic [1:0] count,
    input  logic [1:0] retire_count,
    output rob_id_t    next_id,
    output logic       empty,
    output logic       ready
);

    localparam int OCC_W = $clog2(`ROB_DEPTH + 1);

    logic [OCC_W-1:0] occ;
    logic [OCC_W-1:0] add_n;
    rob_id_t          bundle_id;

    assign add_n = wen ? OCC_W'(count) : '0;

    always_ff @(posedge clk) begin
        if (rst) begin
            occ       <= '0;
            bundle_id <= '0;
        end else begin
            occ <= occ + add_n - OCC_W'(retire_count);
            // one id per bundle, whatever its size
            if (wen) begin
                bundle_id <= bundle_id + 1'b1;
            end
        end
    end

    assign next_id = bundle_id;
    assign empty   = occ == '0;
    // room for a full bundle
    assign ready   = occ <= OCC_W'(`ROB_DEPTH - 2);

    // retire only drains ops already held before this cycle
    a_occ_bounds: assert property (@(posedge clk) disable iff (rst)
        occ <= OCC_W'(`ROB_DEPTH) && OCC_W'(retire_count) <= occ);

endmodule

// File: rtl/sched_pkg.sv
`include "core_defines.svh"

package sched_pkg;

    import uop_pkg::*;

    // counts bundles, two micro-op slots per id
    typedef logic [`ROB_ID_W-1:0] rob_id_t;

    typedef struct packed {
        uop_t uop;
        logic src0_ready;
        logic src1_ready;
        logic is_store;
    } queue_entry_t;

    // hi and lo halves of a multiply travel together
    typedef struct packed {
        uop_t uop_hi;
        uop_t uop_lo;
        logic src0_ready;
        logic src1_ready;
        logic is_mul;
    } mdu_entry_t;

    typedef enum logic [2:0] {
        IDLE,
        WAIT_SLOT0,
        WR_SLOT0,
        WAIT_SLOT1,
        WR_SLOT1,
        DONE
    } dispatch_state_e;

endpackage

// File: rtl/uop_pkg.sv
`include "core_defines.svh"

package uop_pkg;

    typedef logic [`PRF_NUM_W-1:0] prf_num_t;
    typedef logic [`ARCH_W-1:0]    lreg_t;
    typedef logic [5:0]            uop_code_t;
    typedef logic [1:0]            rs_type_t;

    localparam uop_code_t OP_NOP      = 6'd0;
    localparam uop_code_t OP_MDBUBBLE = 6'd1;
    localparam uop_code_t OP_ADD      = 6'd2;
    localparam uop_code_t OP_LW       = 6'd3;
    localparam uop_code_t OP_SB       = 6'd4;
    localparam uop_code_t OP_SH       = 6'd5;
    localparam uop_code_t OP_SW       = 6'd6;
    localparam uop_code_t OP_SWL      = 6'd7;
    localparam uop_code_t OP_SWR      = 6'd8;
    localparam uop_code_t OP_MULTHI   = 6'd9;
    localparam uop_code_t OP_MULTLO   = 6'd10;
    localparam uop_code_t OP_MULTUHI  = 6'd11;
    localparam uop_code_t OP_MULTULO  = 6'd12;

    // none is zero so a cleared record steers nowhere
    localparam rs_type_t RS_NONE = 2'd0;
    localparam rs_type_t RS_ALU  = 2'd1;
    localparam rs_type_t RS_MDU  = 2'd2;
    localparam rs_type_t RS_LSU  = 2'd3;

    typedef struct packed {
        logic               valid;
        logic [31:0]        pc;
        uop_code_t          code;
        rs_type_t           rs_type;
        logic               is_priv;
        logic               src0_en;
        logic               src1_en;
        lreg_t              src0_lreg;
        lreg_t              src1_lreg;
        prf_num_t           src0_preg;
        prf_num_t           src1_preg;
        logic               dst_en;
        prf_num_t           dst_preg;
        // {bundle id, slot}
        logic [`ROB_ID_W:0] id;
        logic               busy;
    } uop_t;

    function automatic logic code_is_store(uop_code_t code);
        return code inside {OP_SB, OP_SH, OP_SW, OP_SWL, OP_SWR};
    endfunction

    function automatic logic code_is_mul(uop_code_t code);
        return code inside {OP_MULTHI, OP_MULTLO, OP_MULTUHI, OP_MULTULO};
    endfunction

endpackage

// File: verification/dispatch_tests.svh
`ifndef DISPATCH_TESTS_SVH
`define DISPATCH_TESTS_SVH

task automatic test_dual_alu();
    uop_t         a, b;
    queue_entry_t ea, eb;
    @(negedge clk);
    check_bit("pause_req", pause_req, 1'b0);
    check_bit("alu_head_valid", alu_head_valid, 1'b0);
    check_bit("lsu_head_valid", lsu_head_valid, 1'b0);
    check_bit("rob_empty", rob_empty, 1'b1);
    a  = make_uop(32'h100, OP_ADD, RS_ALU, rand_dst());
    b  = make_uop(32'h104, OP_ADD, RS_ALU, rand_dst());
    // first bundle after reset carries ids 0 and 1
    ea = expect_entry(a, bundle_cnt, 1'b0, 1'b1, 1'b1);
    eb = expect_entry(b, bundle_cnt, 1'b1, 1'b1, 1'b1);
    send_bundle(a, b);
    pop_check(1'b0, ea, "alu_head slot 0");
    pop_check(1'b0, eb, "alu_head slot 1");
    @(negedge clk);
    check_bit("alu_head_valid", alu_head_valid, 1'b0);
    drain_rob();
    close_test("dual ALU dispatch");
endtask

task automatic test_mixed_steering();
    uop_t         n, s, h, l;
    queue_entry_t en, es;
    n        = make_uop(32'h200, OP_NOP, RS_ALU, '0);
    n.dst_en = 1'b0;
    s        = make_uop(32'h204, OP_SW, RS_LSU, '0);
    s.dst_en = 1'b0;
    en       = expect_entry(n, bundle_cnt, 1'b0, 1'b1, 1'b1);
    es       = expect_entry(s, bundle_cnt, 1'b1, 1'b1, 1'b1);
    send_bundle(n, s);
    // lone LSU op in slot 1 lands on port 0
    pop_check(1'b0, en, "alu_head nop");
    pop_check(1'b1, es, "lsu_head store");
    h = make_uop(32'h208, OP_MULTHI, RS_MDU, rand_dst());
    l = make_uop(32'h20c, OP_MULTLO, RS_MDU, rand_dst());
    send_bundle(h, l);
    check_bit("mdu_valid", seen_mdu_valid, 1'b1);
    check_bit("mdu is_mul", seen_mdu.is_mul, 1'b1);
    check_bit("mdu hi slot", seen_mdu.uop_hi.id[0], 1'b0);
    check_bit("mdu lo slot", seen_mdu.uop_lo.id[0], 1'b1);
    check_preg("mdu lo dst_preg", seen_mdu.uop_lo.dst_preg, l.dst_preg);
    @(negedge clk);
    check_bit("mdu_valid", mdu_valid, 1'b0);
    check_bit("alu_head_valid", alu_head_valid, 1'b0);
    check_bit("lsu_head_valid", lsu_head_valid, 1'b0);
    drain_rob();
    close_test("mixed steering");
endtask

task automatic test_readiness();
    uop_t         p, c, d;
    queue_entry_t ep, ec, ed;
    p           = make_uop(32'h300, OP_ADD, RS_ALU, 6'd10);
    c           = make_uop(32'h304, OP_ADD, RS_ALU, 6'd11);
    c.src0_en   = 1'b1;
    c.src0_lreg = 5'd3;
    c.src0_preg = 6'd10;
    // r0 reads ready even on a register being written
    c.src1_en   = 1'b1;
    c.src1_lreg = 5'd0;
    c.src1_preg = 6'd10;
    ep = expect_entry(p, bundle_cnt, 1'b0, 1'b1, 1'b1);
    ec = expect_entry(c, bundle_cnt, 1'b1, 1'b0, 1'b1);
    send_bundle(p, c);
    pop_check(1'b0, ep, "alu_head producer");
    pop_check(1'b0, ec, "alu_head consumer same bundle");
    d           = make_uop(32'h308, OP_ADD, RS_ALU, 6'd12);
    d.src0_en   = 1'b1;
    d.src0_lreg = 5'd3;
    d.src0_preg = 6'd10;
    ed = expect_entry(d, bundle_cnt, 1'b0, 1'b0, 1'b1);
    send_bundle(d, '0);
    pop_check(1'b0, ed, "alu_head consumer next bundle");
    @(posedge clk);
    wb_num <= 6'd10;
    wb_en  <= 1'b1;
    @(posedge clk);
    wb_en  <= 1'b0;
    d.pc       = 32'h30c;
    d.dst_preg = 6'd13;
    ed = expect_entry(d, bundle_cnt, 1'b0, 1'b1, 1'b1);
    send_bundle(d, '0);
    pop_check(1'b0, ed, "alu_head consumer after writeback");
    drain_rob();
    close_test("readiness");
endtask

task automatic test_priv_serialize();
    uop_t         a, b, x, y;
    queue_entry_t ea, eb, ex, ey;
    logic         dropped;
    a  = make_uop(32'h400, OP_ADD, RS_ALU, rand_dst());
    b  = make_uop(32'h404, OP_ADD, RS_ALU, rand_dst());
    ea = expect_entry(a, bundle_cnt, 1'b0, 1'b1, 1'b1);
    eb = expect_entry(b, bundle_cnt, 1'b1, 1'b1, 1'b1);
    send_bundle(a, b);
    pop_check(1'b0, ea, "alu_head before priv 0");
    pop_check(1'b0, eb, "alu_head before priv 1");
    x         = make_uop(32'h408, OP_ADD, RS_ALU, rand_dst());
    x.is_priv = 1'b1;
    y         = make_uop(32'h40c, OP_ADD, RS_ALU, rand_dst());
    y.is_priv = 1'b1;
    // each enters alone and takes slot bit 0
    ex = expect_entry(x, bundle_cnt, 1'b0, 1'b1, 1'b1);
    ey = expect_entry(y, bundle_cnt + rob_id_t'(1), 1'b0, 1'b1, 1'b1);
    @(posedge clk);
    uop_0 <= x;
    uop_1 <= y;
    repeat (6) begin
        @(negedge clk);
        check_bit("pause_req", pause_req, 1'b1);
        check_bit("alu_head_valid", alu_head_valid, 1'b0);
    end
    retire(2);
    pop_check(1'b0, ex, "alu_head priv 0");
    rob_out++;
    retire(1);
    dropped = 1'b0;
    for (int n = 0; n < WAIT_LIMIT && !dropped; n++) begin
        @(negedge clk);
        dropped = !pause_req;
    end
    if (!dropped) begin
        $display("pause_req never fell after the privileged bundle");
        errors++;
    end
    @(posedge clk);
    uop_0 <= '0;
    uop_1 <= '0;
    pop_check(1'b0, ey, "alu_head priv 1");
    bundle_cnt = bundle_cnt + rob_id_t'(2);
    rob_out++;
    drain_rob();
    close_test("privileged serialization");
endtask

task automatic test_back_pressure();
    uop_t         ops [10];
    queue_entry_t exp [10];
    for (int i = 0; i < 10; i++) begin
        ops[i] = make_uop(32'h500 + 32'(4 * i), OP_ADD, RS_ALU, rand_dst());
        exp[i] = expect_entry(ops[i], bundle_cnt + rob_id_t'(i / 2), 1'(i % 2), 1'b1, 1'b1);
    end
    @(posedge clk);
    stall <= 1'b1;
    fork
        send_bundle(ops[0], ops[1]);
        begin
            repeat (6) begin
                @(negedge clk);
                check_bit("alu_head_valid", alu_head_valid, 1'b0);
            end
            @(posedge clk);
            stall <= 1'b0;
        end
    join
    pop_check(1'b0, exp[0], "alu_head after stall 0");
    pop_check(1'b0, exp[1], "alu_head after stall 1");
    for (int i = 0; i < 10; i++) begin
        exp[i].uop.id[`ROB_ID_W:1] = exp[i].uop.id[`ROB_ID_W:1] + rob_id_t'(1);
    end
    // four bundles fill the ALU queue past its room mark
    for (int i = 0; i < 4; i++) begin
        send_bundle(ops[2 * i], ops[2 * i + 1]);
    end
    fork
        send_bundle(ops[8], ops[9]);
        begin
            repeat (4) begin
                @(negedge clk);
                check_bit("pause_req", pause_req, 1'b1);
                check_entry("alu_head while full", alu_head, exp[0]);
            end
            for (int i = 0; i < 10; i++) begin
                pop_check(1'b0, exp[i], "alu_head held op");
            end
        end
    join
    repeat (2) begin
        @(negedge clk);
        check_bit("alu_head_valid", alu_head_valid, 1'b0);
    end
    drain_rob();
    close_test("back-pressure");
endtask

`endif

// File: verification/dispatch_tb.sv
`timescale 1ns/1ps
`include "core_defines.svh"

module dispatch_tb
    import uop_pkg::*;
    import sched_pkg::*;
();

    localparam int N_TESTS    = 5;
    localparam int WAIT_LIMIT = 100;

    logic         clk, rst, stall;
    uop_t         uop_0, uop_1;
    logic [1:0]   retire_count;
    prf_num_t     wb_num;
    logic         wb_en, alu_pop, lsu_pop;
    logic         pause_req;
    queue_entry_t alu_head, lsu_head;
    logic         alu_head_valid, lsu_head_valid;
    logic         mdu_valid, rob_empty;
    mdu_entry_t   mdu_entry;

    logic [31:0]  lfsr;
    int           errors, errors_at_start, tests_run, tests_failed;
    // tb model of the bundle id counter and ROB occupancy
    rob_id_t      bundle_cnt;
    int           rob_out;
    logic         seen_mdu_valid;
    mdu_entry_t   seen_mdu;

    dispatch_top UUT (
        .clk            (clk),
        .rst            (rst),
        .stall          (stall),
        .uop_0          (uop_0),
        .uop_1          (uop_1),
        .retire_count   (retire_count),
        .wb_num         (wb_num),
        .wb_en          (wb_en),
        .alu_pop        (alu_pop),
        .lsu_pop        (lsu_pop),
        .pause_req      (pause_req),
        .alu_head       (alu_head),
        .alu_head_valid (alu_head_valid),
        .lsu_head       (lsu_head),
        .lsu_head_valid (lsu_head_valid),
        .mdu_valid      (mdu_valid),
        .mdu_entry      (mdu_entry),
        .rob_empty      (rob_empty)
    );

    initial begin
        clk = 1'b0;
        forever #20 clk = ~clk;
    end

    // fibonacci LFSR, taps 32 22 2 1
    function automatic logic lfsr_bit();
        logic fb;
        fb   = lfsr[31] ^ lfsr[21] ^ lfsr[1] ^ lfsr[0];
        lfsr = {lfsr[30:0], fb};
        return fb;
    endfunction

    // upper half only, clear of the fixed registers used for readiness
    function automatic prf_num_t rand_dst();
        prf_num_t n;
        n = '0;
        n[`PRF_NUM_W-1] = 1'b1;
        for (int i = 0; i < `PRF_NUM_W - 1; i++) begin
            n[i] = lfsr_bit();
        end
        return n;
    endfunction

    function automatic uop_t make_uop(input logic [31:0] pc, input uop_code_t code,
                                      input rs_type_t rs, input prf_num_t dst);
        uop_t u;
        u          = '0;
        u.valid    = 1'b1;
        u.pc       = pc;
        u.code     = code;
        u.rs_type  = rs;
        u.dst_en   = 1'b1;
        u.dst_preg = dst;
        return u;
    endfunction

    // entry as the queue should hold it
    function automatic queue_entry_t expect_entry(input uop_t u, input rob_id_t bundle,
                                                  input logic slot, input logic r0,
                                                  input logic r1);
        queue_entry_t e;
        e.uop        = u;
        e.uop.id     = {bundle, slot};
        e.uop.busy   = !(u.code inside {OP_NOP, OP_MDBUBBLE});
        e.src0_ready = r0;
        e.src1_ready = r1;
        e.is_store   = u.code inside {OP_SB, OP_SH, OP_SW, OP_SWL, OP_SWR};
        return e;
    endfunction

    task automatic check_entry(input string name, input queue_entry_t got,
                               input queue_entry_t exp);
        if (got !== exp) begin
            $display("Fail time=%0t %s got=%h exp=%h", $time, name, got, exp);
            errors++;
        end
    endtask

    task automatic check_preg(input string name, input prf_num_t got, input prf_num_t exp);
        if (got !== exp) begin
            $display("Fail time=%0t %s got=%h exp=%h", $time, name, got, exp);
            errors++;
        end
    endtask

    task automatic check_bit(input string name, input logic got, input logic exp);
        if (got !== exp) begin
            $display("Fail time=%0t %s got=%b exp=%b", $time, name, got, exp);
            errors++;
        end
    endtask

    // present a bundle and hold it until dispatch takes it
    task automatic send_bundle(input uop_t u0, input uop_t u1);
        logic accepted;
        accepted = 1'b0;
        @(posedge clk);
        uop_0 <= u0;
        uop_1 <= u1;
        for (int n = 0; n < WAIT_LIMIT && !accepted; n++) begin
            @(negedge clk);
            accepted = !pause_req && !stall;
        end
        if (!accepted) begin
            $display("bundle at pc %h was never accepted by dispatch", u0.pc);
            errors++;
        end
        seen_mdu_valid = mdu_valid;
        seen_mdu       = mdu_entry;
        @(posedge clk);
        uop_0 <= '0;
        uop_1 <= '0;
        bundle_cnt = bundle_cnt + rob_id_t'(1);
        rob_out    = rob_out + int'(u0.valid) + int'(u1.valid);
    endtask

    task automatic pop_check(input logic lsu, input queue_entry_t exp, input string name);
        logic found;
        found = 1'b0;
        for (int n = 0; n < WAIT_LIMIT && !found; n++) begin
            @(negedge clk);
            found = lsu ? lsu_head_valid : alu_head_valid;
        end
        if (!found) begin
            $display("%s never reached the queue head", name);
            errors++;
        end else begin
            check_entry(name, lsu ? lsu_head : alu_head, exp);
        end
        @(posedge clk);
        alu_pop <= !lsu;
        lsu_pop <= lsu;
        @(posedge clk);
        alu_pop <= 1'b0;
        lsu_pop <= 1'b0;
    endtask

    task automatic retire(input int n);
        @(posedge clk);
        retire_count <= 2'(n);
        @(posedge clk);
        retire_count <= 2'd0;
        rob_out = rob_out - n;
    endtask

    task automatic drain_rob();
        while (rob_out > 0) begin
            retire(rob_out > 1 ? 2 : 1);
        end
        @(negedge clk);
        check_bit("rob_empty", rob_empty, 1'b1);
    endtask

    task automatic close_test(input string name);
        tests_run++;
        if (errors != errors_at_start) begin
            tests_failed++;
        end
        $display("%s finished with %0d errors", name, errors - errors_at_start);
        errors_at_start = errors;
    endtask

    `include "dispatch_tests.svh"

    initial begin
        rst             = 1'b1;
        stall           = 1'b0;
        uop_0           = '0;
        uop_1           = '0;
        retire_count    = 2'd0;
        wb_num          = '0;
        wb_en           = 1'b0;
        alu_pop         = 1'b0;
        lsu_pop         = 1'b0;
        lfsr            = 32'h9cea;
        errors          = 0;
        errors_at_start = 0;
        tests_run       = 0;
        tests_failed    = 0;
        bundle_cnt      = '0;
        rob_out         = 0;
        repeat (10) @(posedge clk);
        rst <= 1'b0;
        test_dual_alu();
        test_mixed_steering();
        test_readiness();
        test_priv_serialize();
        test_back_pressure();
        $display("%0d tests run, %0d failed, %0d errors", tests_run, tests_failed, errors);
        if (errors == 0) begin
            $display("TEST RESULT: PASS");
        end else begin
            $display("TEST RESULT: FAIL");
        end
        $finish;
    end

    initial begin
        repeat (400 * N_TESTS) @(posedge clk);
        $display("watchdog expired before the tests completed");
        $display("TEST RESULT: FAIL");
        $finish;
    end

endmodule

// File: vlog.f
+incdir+rtl
+incdir+verification
rtl/uop_pkg.sv
rtl/sched_pkg.sv
rtl/dispatch.sv
rtl/rob_alloc.sv
rtl/issue_queue.sv
rtl/busy_table.sv
rtl/dispatch_top.sv
verification/dispatch_tb.sv
